// ==== flist.f ====
logic/vend_pkg.sv
logic/vend_ctrl_if.sv
logic/key_filter.sv
logic/idle_timer.sv
logic/vend_fsm.sv
logic/credit_ledger.sv
logic/vend_top.sv
test/vend_sva.sv
test/vend_tb.sv

// ==== logic/credit_ledger.sv ====
// Credit ledger: credit register, opcode execution, dispense, refund and change outputs
`timescale 1ns/10ps

module credit_ledger (
	input  logic                          clk,
	input  logic                          rst_n,
	vend_ctrl_if.ledger                   ctrl,
	output logic [vend_pkg::CREDIT_W-1:0] credit,
	output logic                          dispense,
	output logic                          refund,
	output logic [vend_pkg::CREDIT_W-1:0] change
);
	import vend_pkg::*;

	logic [CREDIT_W-1:0] credit_q;
	// Coin value of the current op, zero otherwise
	logic [CREDIT_W-1:0] coin_val;
	// One extra bit to catch overflow
	logic [CREDIT_W:0]   sum;
	logic [CREDIT_W-1:0] added;

	// ----------------------------------------
	// Coin addition
	// ----------------------------------------

	always_comb begin
		case (ctrl.op)
			OP_ADD_HALF: coin_val = CREDIT_W'(1);
			OP_ADD_ONE:  coin_val = CREDIT_W'(2);
			default:     coin_val = '0;
		endcase
		sum = {1'b0, credit_q} + {1'b0, coin_val};
	end

	// Saturate at all ones
	assign added = sum[CREDIT_W] ? '1 : sum[CREDIT_W-1:0];

	// ----------------------------------------
	// Opcode execution
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_q <= '0;
			dispense <= 1'b0;
			refund   <= 1'b0;
			change   <= '0;
		end else begin
			// Pulses and change last one cycle
			dispense <= 1'b0;
			refund   <= 1'b0;
			change   <= '0;
			case (ctrl.op)
				OP_ADD_HALF, OP_ADD_ONE: begin
					credit_q <= added;
				end
				OP_SETTLE: begin
					dispense <= 1'b1;
					change   <= credit_q - PRICE;
					credit_q <= '0;
				end
				OP_REFUND: begin
					refund   <= 1'b1;
					change   <= credit_q;
					credit_q <= '0;
				end
				default: begin
					credit_q <= credit_q;
				end
			endcase
		end
	end

	// Status back to the FSM, derived from the shared credit
	assign ctrl.credit = credit_q;
	assign ctrl.paid   = (ctrl.credit >= PRICE);
	assign ctrl.empty  = (ctrl.credit == '0);
	assign credit      = ctrl.credit;

endmodule

// ==== logic/idle_timer.sv ====
// Idle timer: saturating inactivity counter with expiry pulse and idle level
`timescale 1ns/10ps

module idle_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic ev_any,
	output logic expire,
	output logic idle
);
	import vend_pkg::*;

	logic [IDLE_W-1:0] cnt;

	// Starts saturated, so idle is high out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= IDLE_W'(IDLE_CYCLES);
		end else if (ev_any) begin
			cnt <= '0;
		end else if (cnt != IDLE_W'(IDLE_CYCLES)) begin
			cnt <= cnt + 1'b1;
		end
	end

	// One pulse on the edge where the count saturates
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			expire <= 1'b0;
		end else begin
			expire <= !ev_any && (cnt == IDLE_W'(IDLE_CYCLES - 1));
		end
	end

	// High from expiry until the count restarts
	assign idle = (cnt == IDLE_W'(IDLE_CYCLES));

endmodule

// ==== logic/key_filter.sv ====
// Key debouncer: three active-low key counters and prioritized one-cycle key events
`timescale 1ns/10ps

module key_filter (
	input  logic       clk,
	input  logic       rst_n,
	// [0] half coin, [1] one coin, [2] cancel, all active low
	input  logic [2:0] keys,
	output logic       ev_half,
	output logic       ev_one,
	output logic       ev_cancel,
	output logic       ev_any
);
	import vend_pkg::*;

	logic [DEBOUNCE_W-1:0] cnt [3];
	// Threshold reached this sample, per key
	logic [2:0] hit;

	// ----------------------------------------
	// Debounce counters
	// ----------------------------------------

	for (genvar i = 0; i < 3; i++) begin : g_key
		// Restart while released, saturate at the threshold
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt[i] <= '0;
			end else if (keys[i]) begin
				cnt[i] <= '0;
			end else if (cnt[i] != DEBOUNCE_W'(DEBOUNCE_CYCLES)) begin
				cnt[i] <= cnt[i] + 1'b1;
			end
		end

		// Nth consecutive low sample, only once per press
		assign hit[i] = !keys[i] && (cnt[i] == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));
	end

	// ----------------------------------------
	// Event pulses
	// ----------------------------------------

	// Fixed priority: half, then one, then cancel
	// Lower-priority hits in the same cycle are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ev_half   <= 1'b0;
			ev_one    <= 1'b0;
			ev_cancel <= 1'b0;
		end else begin
			ev_half   <= hit[0];
			ev_one    <= hit[1] && !hit[0];
			ev_cancel <= hit[2] && !hit[1] && !hit[0];
		end
	end

	// Activity flag for the idle timer
	assign ev_any = ev_half | ev_one | ev_cancel;

endmodule

// ==== logic/vend_ctrl_if.sv ====
// Control interface between vending FSM and credit ledger, with fsm and ledger modports
`timescale 1ns/10ps

interface vend_ctrl_if;
	import vend_pkg::*;

	// Opcode for the ledger, valid every cycle
	ledger_op_e op;

	// Ledger status back to the FSM
	logic [CREDIT_W-1:0] credit;
	// Credit at or above PRICE
	logic paid;
	// Credit is zero
	logic empty;

	// FSM side issues ops and watches ledger status
	modport fsm (
		output op,
		input  paid,
		input  empty
	);

	// Ledger side applies ops and reports credit
	modport ledger (
		input  op,
		output credit,
		output paid,
		output empty
	);

endinterface

// ==== logic/vend_fsm.sv ====
// Vending FSM: maps key events and idle expiry to ledger opcodes, holds one pending coin
`timescale 1ns/10ps

module vend_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic ev_half,
	input  logic ev_one,
	input  logic ev_cancel,
	input  logic expire,
	vend_ctrl_if.fsm ctrl
);
	import vend_pkg::*;

	vend_state_e state_q, state_d;
	ledger_op_e  op_q, op_d;
	// Coin waiting for a free ledger slot
	ledger_op_e  pend_q, pend_d;
	// Coin op for this cycle's event, if any
	ledger_op_e  coin_op;
	// Last op was a coin, so paid and empty are one cycle stale
	logic        busy;

	// Events are already exclusive out of the filter
	assign coin_op = ev_half ? OP_ADD_HALF : (ev_one ? OP_ADD_ONE : OP_NONE);
	assign busy    = (op_q == OP_ADD_HALF) || (op_q == OP_ADD_ONE);

	// ----------------------------------------
	// Next state and next opcode
	// ----------------------------------------

	always_comb begin
		state_d = state_q;
		op_d    = OP_NONE;
		pend_d  = pend_q;

		case (state_q)
			EMPTY: begin
				// Cancel and expiry mean nothing without credit
				if (coin_op != OP_NONE) begin
					op_d    = coin_op;
					state_d = COLLECT;
				end
			end

			COLLECT: begin
				if (!busy && ctrl.paid) begin
					// Settle first, keep any coin for afterwards
					op_d    = OP_SETTLE;
					state_d = VEND;
					if (coin_op != OP_NONE) begin
						pend_d = coin_op;
					end
				end else if (ev_cancel || expire) begin
					// A coin op still in flight lands before the refund
					op_d    = OP_REFUND;
					state_d = RETURN;
				end else if (coin_op != OP_NONE) begin
					if (busy) begin
						pend_d = coin_op;
					end else begin
						op_d = coin_op;
					end
				end else if (!busy && pend_q != OP_NONE) begin
					// Replay the held coin once credit is settled
					op_d   = pend_q;
					pend_d = OP_NONE;
				end else if (!busy && ctrl.empty) begin
					state_d = EMPTY;
				end
			end

			VEND, RETURN: begin
				// Ledger applies settle or refund in this cycle
				if (pend_q != OP_NONE) begin
					op_d    = pend_q;
					pend_d  = coin_op;
					state_d = COLLECT;
				end else if (coin_op != OP_NONE) begin
					op_d    = coin_op;
					state_d = COLLECT;
				end else begin
					state_d = EMPTY;
				end
			end

			default: begin
				state_d = EMPTY;
			end
		endcase
	end

	// ----------------------------------------
	// State registers
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= EMPTY;
			op_q    <= OP_NONE;
			pend_q  <= OP_NONE;
		end else begin
			state_q <= state_d;
			op_q    <= op_d;
			pend_q  <= pend_d;
		end
	end

	// Registered op, one cycle after the event
	assign ctrl.op = op_q;

endmodule

// ==== logic/vend_pkg.sv ====
// Vending controller package: timing constants, credit widths, price, FSM and opcode enums
package vend_pkg;

	// ----------------------------------------
	// Timing, sized for simulation
	// ----------------------------------------

	// Consecutive low samples before a key counts as pressed
	localparam int DEBOUNCE_CYCLES = 8;
	// Counter width, must hold DEBOUNCE_CYCLES itself
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);

	// Cycles without any key event before idle expiry
	localparam int IDLE_CYCLES = 200;
	// Saturates at IDLE_CYCLES
	localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

	// ----------------------------------------
	// Credit, in half-yuan units
	// ----------------------------------------

	localparam int CREDIT_W = 4;
	// 2.5 yuan
	localparam logic [CREDIT_W-1:0] PRICE = CREDIT_W'(5);

	// ----------------------------------------
	// Control encodings
	// ----------------------------------------

	// Controller states
	typedef enum logic [1:0] {
		EMPTY   = 2'd0,
		COLLECT = 2'd1,
		VEND    = 2'd2,
		RETURN  = 2'd3
	} vend_state_e;

	// Ledger opcodes, one per cycle
	typedef enum logic [2:0] {
		OP_NONE     = 3'd0,
		OP_ADD_HALF = 3'd1,
		OP_ADD_ONE  = 3'd2,
		OP_SETTLE   = 3'd3,
		OP_REFUND   = 3'd4
	} ledger_op_e;

endpackage

// ==== logic/vend_top.sv ====
// Vending controller top level: key filter, idle timer, FSM and credit ledger
`timescale 1ns/10ps

module vend_top (
	input  logic                          clk,
	input  logic                          rst_n,
	// Active low: [0] half coin, [1] one coin, [2] cancel
	input  logic [2:0]                    keys,
	output logic [vend_pkg::CREDIT_W-1:0] credit,
	output logic                          idle,
	output logic                          dispense,
	output logic                          refund,
	output logic [vend_pkg::CREDIT_W-1:0] change
);

	// Key event pulses
	logic ev_half;
	logic ev_one;
	logic ev_cancel;
	logic ev_any;
	// Inactivity expiry pulse
	logic expire;

	// FSM to ledger bundle
	vend_ctrl_if ctrl_if ();

	// ----------------------------------------
	// Key input side
	// ----------------------------------------

	key_filter u_key_filter (
		.clk       (clk),
		.rst_n     (rst_n),
		.keys      (keys),
		.ev_half   (ev_half),
		.ev_one    (ev_one),
		.ev_cancel (ev_cancel),
		.ev_any    (ev_any)
	);

	idle_timer u_idle_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.ev_any (ev_any),
		.expire (expire),
		.idle   (idle)
	);

	// ----------------------------------------
	// Control and credit
	// ----------------------------------------

	vend_fsm u_vend_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.ev_half   (ev_half),
		.ev_one    (ev_one),
		.ev_cancel (ev_cancel),
		.expire    (expire),
		.ctrl      (ctrl_if.fsm)
	);

	credit_ledger u_credit_ledger (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl_if.ledger),
		.credit   (credit),
		.dispense (dispense),
		.refund   (refund),
		.change   (change)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the vending controller simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module vend_tb \
	-f flist.f \
	-o vend_sim

./obj_dir/vend_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== test/vend_sva.sv ====
// Output protocol and idle refund assertions bound into the vending top level
`timescale 1ns/10ps

module vend_sva (
	input logic                          clk,
	input logic                          rst_n,
	input logic [vend_pkg::CREDIT_W-1:0] credit,
	input logic                          idle,
	input logic                          dispense,
	input logic                          refund,
	input logic [vend_pkg::CREDIT_W-1:0] change
);
	import vend_pkg::*;

	// ----------------------------------------
	// Output pulses
	// ----------------------------------------

	// Settle and refund never share a cycle
	a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		!(dispense && refund))
		else $error("dispense and refund high together");

	// Change only valid with a pulse
	a_change_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(!dispense && !refund) |-> (change == '0))
		else $error("change nonzero outside a pulse");

	// Single-cycle pulses
	a_disp_short: assert property (@(posedge clk) disable iff (!rst_n)
		dispense |=> !dispense)
		else $error("dispense longer than one cycle");

	a_ref_short: assert property (@(posedge clk) disable iff (!rst_n)
		refund |=> !refund)
		else $error("refund longer than one cycle");

	// ----------------------------------------
	// Credit and idle
	// ----------------------------------------

	// Highest reachable is PRICE-1 plus a one coin
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		int'(credit) < int'(PRICE) + 2)
		else $error("credit above reachable maximum");

	// Expiry with credit left returns it two cycles later
	a_idle_refund: assert property (@(posedge clk) disable iff (!rst_n)
		($rose(idle) && credit != '0) |-> ##2 (credit == '0))
		else $error("credit not returned after idle expiry");

endmodule

bind vend_top vend_sva u_vend_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.credit   (credit),
	.idle     (idle),
	.dispense (dispense),
	.refund   (refund),
	.change   (change)
);

// ==== test/vend_tb.sv ====
// Vending controller testbench: clock, reset, seeded random key presses, reference model, checks
`timescale 1ns/10ps

module vend_tb;
	import vend_pkg::*;

	// ----------------------------------------
	// Test length and cycle limit
	// ----------------------------------------

	localparam int N_DIRECTED = 9;
	localparam int N_RANDOM   = 80;
	localparam int HOLD       = DEBOUNCE_CYCLES + 4;
	// Press, longest release gap, pulse wait slack
	localparam int STEP_MAX   = HOLD + 20 + 10;
	localparam int LONG_MAX   = IDLE_CYCLES + 40;
	localparam int LIMIT      = 10 + (N_DIRECTED + N_RANDOM) * STEP_MAX
		+ (N_RANDOM / 10 + 1) * LONG_MAX + 100;

	logic                clk = 1'b0;
	logic                rst_n;
	logic [2:0]          keys;
	logic [CREDIT_W-1:0] credit;
	logic                idle;
	logic                dispense;
	logic                refund;
	logic [CREDIT_W-1:0] change;

	integer seed = 32'h7552_8bfe;
	int     cycles = 0;
	int     fail_count = 0;
	// Reference credit in half-yuan units
	int     model_credit = 0;
	// Change values seen on the output pulses
	int     disp_q[$];
	int     ref_q[$];

	vend_top DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.keys     (keys),
		.credit   (credit),
		.idle     (idle),
		.dispense (dispense),
		.refund   (refund),
		.change   (change)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// Hard stop if the run stalls
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Test FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// Collect output pulses away from the active edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (dispense) begin
				disp_q.push_back(int'(change));
			end
			if (refund) begin
				ref_q.push_back(int'(change));
			end
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic check(input string what, input int actual, input int expected);
		if (actual !== expected) begin
			fail_count = fail_count + 1;
			$display("error: time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Bounded by the cycle limit
	task automatic wait_pulses(input int n);
		while (disp_q.size() + ref_q.size() < n) begin
			next_cycle();
		end
	endtask

	task automatic check_pulses(input int exp_disp, input int exp_ref, input int exp_change);
		check("dispense pulse count", disp_q.size(), exp_disp);
		check("refund pulse count", ref_q.size(), exp_ref);
		if (exp_disp != 0) begin
			check("change on dispense", disp_q[0], exp_change);
		end
		if (exp_ref != 0) begin
			check("change on refund", ref_q[0], exp_change);
		end
		disp_q.delete();
		ref_q.delete();
	endtask

	// ----------------------------------------
	// Stimulus steps with model update
	// ----------------------------------------

	// Key 0 half coin, 1 one coin, 2 cancel
	task automatic run_press(input int key, input int hold, input int gap);
		int exp_disp;
		int exp_ref;
		int exp_change;
		bit counted;

		exp_disp   = 0;
		exp_ref    = 0;
		exp_change = 0;
		counted    = (hold >= DEBOUNCE_CYCLES);
		if (counted && key != 2) begin
			model_credit = model_credit + ((key == 0) ? 1 : 2);
			if (model_credit >= int'(PRICE)) begin
				exp_disp     = 1;
				exp_change   = model_credit - int'(PRICE);
				model_credit = 0;
			end
		end else if (counted && model_credit > 0) begin
			exp_ref      = 1;
			exp_change   = model_credit;
			model_credit = 0;
		end

		keys = ~(3'b001 << key);
		repeat (hold) next_cycle();
		keys = 3'b111;
		wait_pulses(exp_disp + exp_ref);
		repeat (gap) next_cycle();

		check_pulses(exp_disp, exp_ref, exp_change);
		check("credit", int'(credit), model_credit);
		// Any accepted key restarts the idle count
		if (counted) begin
			check("idle after key", int'(idle), 0);
		end
	endtask

	// No keys for longer than the idle period
	task automatic run_idle_gap(input int gap);
		int exp_ref;
		int exp_change;

		exp_ref      = (model_credit > 0) ? 1 : 0;
		exp_change   = model_credit;
		model_credit = 0;
		repeat (gap) next_cycle();
		check_pulses(0, exp_ref, exp_change);
		check("credit after idle", int'(credit), 0);
		check("idle after gap", int'(idle), 1);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		int r;
		int key;
		bit short_press;
		bit last_short;

		last_short = 1'b0;
		rst_n = 1'b0;
		keys  = 3'b111;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Reset values
		check("credit after reset", int'(credit), 0);
		check("idle after reset", int'(idle), 1);
		check("dispense after reset", int'(dispense), 0);
		check("refund after reset", int'(refund), 0);
		check("change after reset", int'(change), 0);

		// Directed: bounce, empty cancel, idle refund, cancel refund, purchase
		run_press(0, DEBOUNCE_CYCLES - 1, 10);
		run_press(2, HOLD, 10);
		run_press(0, HOLD, 10);
		run_idle_gap(IDLE_CYCLES + 20);
		run_press(1, HOLD, 10);
		run_press(2, HOLD, 10);
		run_press(1, HOLD, 10);
		run_press(1, HOLD, 10);
		run_press(1, HOLD, 10);

		// Random presses, a long gap every tenth step
		for (int i = 0; i < N_RANDOM; i++) begin
			if (i % 10 == 9) begin
				run_idle_gap(rand_range(IDLE_CYCLES + 10, IDLE_CYCLES + 40));
				last_short = 1'b0;
			end else begin
				r   = rand_range(0, 15);
				key = (r < 6) ? 0 : ((r < 12) ? 1 : 2);
				// Never two bounces in a row, keeps the idle timer quiet
				short_press = !last_short && (rand_range(0, 7) == 0);
				if (short_press) begin
					run_press(key, rand_range(1, DEBOUNCE_CYCLES - 1), rand_range(4, 20));
				end else begin
					run_press(key, HOLD, rand_range(4, 20));
				end
				last_short = short_press;
			end
		end

		if (fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
